// ==== bt_link.f ====
+incdir+verification
source/uart_pkg.sv
source/bt_link_pkg.sv
source/uart_tx.sv
source/uart_rx.sv
source/sync_fifo.sv
source/line_end_detector.sv
source/bt_link_controller.sv
source/bt_link_top.sv
verification/bt_link_tb.sv

// ==== Makefile ====
TOOL = verilator
FLAGS = --binary --timing -j 0
TOP = bt_link_tb
FILE_LIST = bt_link.f
OBJ_DIR = obj_dir
LOG = sim.log
BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: compile
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "NO ERRORS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verification/uart_model.svh ====
`ifndef UART_MODEL_SVH
`define UART_MODEL_SVH

// ----------------------------------------------------------
// UART line model on the module side of the link
// ----------------------------------------------------------

// Samples txd_o at bit centres, one frame per call
task automatic decode_frame(output byte_t data);
	int guard;
	guard = 0;
	while (txd_o)
	begin
		@(negedge clock);
		guard++;
		if (guard > WAIT_LIMIT)
			timeout_fail("waiting for a start bit on txd_o");
	end
	repeat (HALF_BIT) @(negedge clock); // Centre of the start bit
	check_equal(int'(txd_o), 0, "start bit on txd_o");
	for (int i = 0; i < DATA_BITS; i++)
	begin
		repeat (CLOCKS_PER_BIT) @(negedge clock);
		data[i] = txd_o; // LSB first
	end
	repeat (CLOCKS_PER_BIT) @(negedge clock);
	check_equal(int'(txd_o), 1, "stop bit on txd_o");
endtask

// Drives one 8N1 frame on rxd_i and leaves the line idle high
task automatic drive_frame(input byte_t data);
	logic [FRAME_BITS-1:0] frame;
	frame = {1'b1, data, 1'b0}; // Stop bit, data bits, start bit
	for (int i = 0; i < FRAME_BITS; i++)
	begin
		rxd_i = frame[i];
		repeat (CLOCKS_PER_BIT) drive_edge();
	end
endtask

`endif

// ==== verification/bt_link_tb.sv ====
`timescale 1ns/10ps

module bt_link_tb;
	import uart_pkg::*;
	import bt_link_pkg::*;

	localparam int ROWS = 4;
	localparam int WAIT_LIMIT = 2000; // Cycles allowed for any single wait

	// Word and response lists hold their first entry in the top bits
	typedef struct packed {
		logic [63:0] words;
		logic [2:0] n_words;
		logic expect_resp;
		logic [7:0] connect_delay;
		logic [63:0] resp;
		logic [3:0] n_resp;
		logic [2:0] stall_bits; // LFSR bits per read stall
	} row_t;

	localparam row_t TABLE [ROWS] = '{
		{64'h1234_ABCD_0000_0000, 3'd2, 1'b0, 8'd3, 64'h0, 4'd0, 3'd0},
		{64'h0D0A_5A00_FFFF_0000, 3'd3, 1'b1, 8'd0, 64'h4F4B_0D0A_5800_0000, 4'd5, 3'd3},
		{64'h8001_0000_0000_0000, 3'd1, 1'b1, 8'd6, 64'h410D_420D_0A5A_0000, 4'd6, 3'd5},
		{64'h00FF_7E81_0000_0000, 3'd2, 1'b0, 8'd1, 64'h0, 4'd0, 3'd0}
	};

	logic clock;
	logic reset;
	logic word_valid_i;
	word_t word_i;
	logic word_ready_o;
	logic byte_valid_o;
	byte_t byte_o;
	logic byte_ready_i;
	link_cmd_t cmd_i;
	logic busy_o;
	logic bt_state_i;
	logic bt_enable_o;
	logic txd_o;
	logic rxd_i;
	logic [15:0] lfsr_q = 16'd21;

	bt_link_top i_dut (.*);

	initial
	begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// ----------------------------------------------------------
	// Helpers
	// ----------------------------------------------------------
	task automatic drive_edge();
		@(posedge clock);
		#10;
	endtask

	function automatic int random_bits(int count);
		int value;
		logic fb;
		value = 0;
		for (int i = 0; i < count; i++)
		begin
			fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]; // Taps 16 14 13 11
			lfsr_q = {lfsr_q[14:0], fb};
			value = (value << 1) | int'(fb);
		end
		return value;
	endfunction

	task automatic check_equal(int actual, int expected, string what);
		if (actual != expected)
		begin
			$display("** Error at %0d ns: %s is %0h, expected %0h", $time, what, actual, expected);
			$display("ERRORS FOUND");
			$fatal(1, "Mismatch");
		end
	endtask

	task automatic timeout_fail(string what);
		$display("Timeout while %s", what);
		$display("ERRORS FOUND");
		$fatal(1, "Timeout");
	endtask

	`include "uart_model.svh"

	function automatic word_t word_at(row_t row, int index);
		return row.words[63 - 16 * index -: 16];
	endfunction

	function automatic byte_t resp_byte(row_t row, int index);
		return row.resp[63 - 8 * index -: 8];
	endfunction

	// Bytes up to and including the first CR LF pair
	function automatic int line_length(row_t row);
		for (int i = 0; i + 1 < int'(row.n_resp); i++)
		begin
			if (resp_byte(row, i) == CHAR_CR && resp_byte(row, i + 1) == CHAR_LF)
				return i + 2;
		end
		return int'(row.n_resp);
	endfunction

	// ----------------------------------------------------------
	// Exchange steps
	// ----------------------------------------------------------
	task automatic push_words(row_t row);
		int guard;
		for (int i = 0; i < int'(row.n_words); i++)
		begin
			word_valid_i = 1'b1;
			word_i = word_at(row, i);
			guard = 0;
			@(negedge clock);
			while (!word_ready_o)
			begin
				@(negedge clock);
				guard++;
				if (guard > WAIT_LIMIT)
					timeout_fail("pushing a word into the transmit FIFO");
			end
			drive_edge();
		end
		word_valid_i = 1'b0;
	endtask

	task automatic check_transmit(row_t row);
		word_t expected;
		byte_t got;
		for (int i = 0; i < int'(row.n_words); i++)
		begin
			expected = word_at(row, i);
			decode_frame(got);
			check_equal(int'(got), int'(expected[15:8]), "high byte on txd_o");
			decode_frame(got);
			check_equal(int'(got), int'(expected[7:0]), "low byte on txd_o");
		end
	endtask

	task automatic send_response(row_t row);
		repeat (CLOCKS_PER_BIT + random_bits(3)) drive_edge(); // Last transmit frame ends first
		for (int i = 0; i < int'(row.n_resp); i++)
		begin
			drive_frame(resp_byte(row, i));
			repeat (random_bits(3)) drive_edge();
		end
	endtask

	task automatic read_response(row_t row, int count);
		int got;
		int guard;
		int stall;
		logic held;
		byte_t held_byte;
		got = 0;
		guard = 0;
		stall = 0;
		held = 1'b0;
		held_byte = '0;
		while (got < count)
		begin
			drive_edge();
			if (stall > 0)
			begin
				byte_ready_i = 1'b0;
				stall--;
			end
			else
			begin
				byte_ready_i = 1'b1;
				stall = random_bits(int'(row.stall_bits));
			end
			@(negedge clock);
			if (held)
			begin
				check_equal(int'(byte_valid_o), 1, "byte_valid_o while stalled");
				check_equal(int'(byte_o), int'(held_byte), "byte_o while stalled");
			end
			held = byte_valid_o & ~byte_ready_i;
			held_byte = byte_o;
			if (byte_valid_o && byte_ready_i)
			begin
				check_equal(int'(byte_o), int'(resp_byte(row, got)), "response byte on byte_o");
				got++;
				guard = 0;
			end
			else
			begin
				guard++;
				if (guard > WAIT_LIMIT)
					timeout_fail("waiting for a response byte on byte_o");
			end
		end
		drive_edge();
		byte_ready_i = 1'b0; // Any later byte stays visible for the final check
	endtask

	task automatic run_row(row_t row);
		int guard;
		push_words(row);
		cmd_i.start = 1'b1;
		cmd_i.expect_response = row.expect_resp;
		drive_edge();
		@(negedge clock);
		check_equal(int'(busy_o), 1, "busy_o after start");
		check_equal(int'(bt_enable_o), 1, "bt_enable_o after start");
		repeat (int'(row.connect_delay))
		begin
			@(negedge clock);
			check_equal(int'(txd_o), 1, "txd_o before connection");
		end
		drive_edge();
		bt_state_i = 1'b1;
		fork
			begin
				check_transmit(row);
				if (row.expect_resp)
					send_response(row);
			end
			read_response(row, row.expect_resp ? line_length(row) : 0);
		join
		guard = 0;
		while (busy_o)
		begin
			@(negedge clock);
			guard++;
			if (guard > WAIT_LIMIT)
				timeout_fail("waiting for busy_o to drop after an exchange");
		end
		repeat (3)
		begin
			@(negedge clock);
			check_equal(int'(busy_o), 0, "busy_o in done");
		end
		check_equal(int'(bt_enable_o), 0, "bt_enable_o in done");
		check_equal(int'(byte_valid_o), 0, "byte_valid_o after the line end");
		drive_edge();
		cmd_i = '0;
		bt_state_i = 1'b0;
		repeat (2) drive_edge();
	endtask

	initial
	begin
		word_valid_i = 1'b0;
		word_i = '0;
		byte_ready_i = 1'b0;
		cmd_i = '0;
		bt_state_i = 1'b0;
		rxd_i = 1'b1;
		reset = 1'b1;
		repeat (5) @(posedge clock);
		#10;
		reset = 1'b0;
		@(negedge clock);
		check_equal(int'(txd_o), 1, "txd_o after reset");
		check_equal(int'(bt_enable_o), 0, "bt_enable_o after reset");
		check_equal(int'(busy_o), 0, "busy_o after reset");
		check_equal(int'(byte_valid_o), 0, "byte_valid_o after reset");
		drive_edge();
		for (int r = 0; r < ROWS; r++)
			run_row(TABLE[r]);
		$display("NO ERRORS");
		$finish;
	end

endmodule

// ==== source/bt_link_top.sv ====
`timescale 1ns/10ps

module bt_link_top (
	input logic clock,
	input logic reset,
	input logic word_valid_i,
	input bt_link_pkg::word_t word_i,
	output logic word_ready_o,
	output logic byte_valid_o,
	output bt_link_pkg::byte_t byte_o,
	input logic byte_ready_i,
	input bt_link_pkg::link_cmd_t cmd_i,
	output logic busy_o,
	input logic bt_state_i,
	output logic bt_enable_o,
	output logic txd_o,
	input logic rxd_i
);
	import bt_link_pkg::*;

	word_t fifo_word;
	logic fifo_word_valid;
	logic fifo_word_pop;
	byte_t tx_byte;
	logic tx_valid;
	logic tx_ready;
	byte_t rx_byte;
	logic rx_valid;
	logic rx_push;
	logic line_end;
	logic detect_clear;

	// ----------------------------------------------------------
	// Host side FIFOs
	// ----------------------------------------------------------
	sync_fifo #(.payload_t(word_t), .DEPTH(TX_DEPTH)) tx_fifo (
		.clock(clock), .reset(reset),
		.data_i(word_i), .valid_i(word_valid_i), .ready_o(word_ready_o),
		.data_o(fifo_word), .valid_o(fifo_word_valid), .ready_i(fifo_word_pop)
	);

	sync_fifo #(.payload_t(byte_t), .DEPTH(RX_DEPTH)) rx_fifo (
		.clock(clock), .reset(reset),
		.data_i(rx_byte), .valid_i(rx_push), .ready_o(), // Sized so it never fills
		.data_o(byte_o), .valid_o(byte_valid_o), .ready_i(byte_ready_i)
	);

	// ----------------------------------------------------------
	// Serial line and control
	// ----------------------------------------------------------
	uart_tx tx (
		.clock(clock), .reset(reset),
		.data_i(tx_byte), .valid_i(tx_valid), .ready_o(tx_ready), .txd_o(txd_o)
	);

	uart_rx rx (
		.clock(clock), .reset(reset),
		.rxd_i(rxd_i), .data_o(rx_byte), .valid_o(rx_valid)
	);

	line_end_detector detector (
		.clock(clock), .reset(reset),
		.byte_i(rx_byte), .strobe_i(rx_push), .clear_i(detect_clear), .line_end_o(line_end)
	);

	bt_link_controller controller (
		.clock(clock), .reset(reset),
		.cmd_i(cmd_i), .bt_state_i(bt_state_i),
		.word_i(fifo_word), .word_valid_i(fifo_word_valid), .word_ready_o(fifo_word_pop),
		.tx_data_o(tx_byte), .tx_valid_o(tx_valid), .tx_ready_i(tx_ready),
		.rx_valid_i(rx_valid), .rx_push_o(rx_push),
		.line_end_i(line_end), .detect_clear_o(detect_clear),
		.busy_o(busy_o), .bt_enable_o(bt_enable_o)
	);

endmodule

// ==== source/bt_link_controller.sv ====
`timescale 1ns/10ps

module bt_link_controller (
	input logic clock,
	input logic reset,
	input bt_link_pkg::link_cmd_t cmd_i,
	input logic bt_state_i,
	input bt_link_pkg::word_t word_i,
	input logic word_valid_i,
	output logic word_ready_o,
	output bt_link_pkg::byte_t tx_data_o,
	output logic tx_valid_o,
	input logic tx_ready_i,
	input logic rx_valid_i,
	output logic rx_push_o,
	input logic line_end_i,
	output logic detect_clear_o,
	output logic busy_o,
	output logic bt_enable_o
);
	import bt_link_pkg::*;

	link_state_t state;
	link_state_t next;
	logic high_sel;
	logic expect_q;
	logic tx_accept;
	logic active;

	// ----------------------------------------------------------
	// Outputs decoded from the state
	// ----------------------------------------------------------
	assign active = (state != idle) && (state != done);
	assign busy_o = active;
	assign bt_enable_o = active;
	assign tx_valid_o = (state == send_byte);
	assign tx_data_o = high_sel ? word_i[15:8] : word_i[7:0]; // High byte goes first
	assign tx_accept = tx_valid_o & tx_ready_i;
	assign word_ready_o = tx_accept & ~high_sel; // Pop once the low byte is taken
	assign rx_push_o = (state == receive) & rx_valid_i;
	assign detect_clear_o = (state == receive) & line_end_i;

	// ----------------------------------------------------------
	// Next state
	// ----------------------------------------------------------
	always_comb
	begin
		next = state;
		case (state)
			idle: if (cmd_i.start) next = wait_connect;
			wait_connect: if (bt_state_i) next = load_byte;
			load_byte:
			begin
				if (word_valid_i)
					next = send_byte;
				else if (tx_ready_i) // Let the last frame leave the line first
					next = expect_q ? receive : done;
			end
			send_byte: if (tx_ready_i) next = load_byte;
			receive: if (line_end_i) next = done;
			done: if (!cmd_i.start) next = idle;
			default: next = idle;
		endcase
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= idle;
			high_sel <= 1'b1;
		end
		else
		begin
			state <= next;
			if (state == idle)
				high_sel <= 1'b1;
			else if (tx_accept)
				high_sel <= ~high_sel;
		end
	end

	always_ff @(posedge clock)
	begin
		if (state == idle && cmd_i.start)
			expect_q <= cmd_i.expect_response;
	end

endmodule

// ==== source/line_end_detector.sv ====
`timescale 1ns/10ps

module line_end_detector (
	input logic clock,
	input logic reset,
	input bt_link_pkg::byte_t byte_i,
	input logic strobe_i,
	input logic clear_i,
	output logic line_end_o
);
	import bt_link_pkg::*;

	typedef enum logic [1:0] {beginning, found_cr, line_end} detect_state_t;

	detect_state_t state;

	assign line_end_o = (state == line_end);

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			state <= beginning;
		else if (clear_i)
			state <= beginning;
		else if (strobe_i && state != line_end) // End is held until cleared
		begin
			if (byte_i == CHAR_CR)
				state <= found_cr;
			else if (byte_i == CHAR_LF && state == found_cr)
				state <= line_end;
			else
				state <= beginning;
		end
	end

endmodule

// ==== source/sync_fifo.sv ====
`timescale 1ns/10ps

module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 16
) (
	input logic clock,
	input logic reset,
	input payload_t data_i,
	input logic valid_i,
	output logic ready_o,
	output payload_t data_o,
	output logic valid_o,
	input logic ready_i
);
	// With a power of two depth the pointers wrap by overflow
	typedef logic [$clog2(DEPTH)-1:0] ptr_t;
	typedef logic [$clog2(DEPTH+1)-1:0] count_t;

	payload_t mem [DEPTH];
	ptr_t wr_ptr;
	ptr_t rd_ptr;
	count_t count;
	logic push;
	logic pop;

	assign ready_o = (count != count_t'(DEPTH));
	assign valid_o = (count != '0);
	assign data_o = mem[rd_ptr]; // Head of the queue shows while not empty
	assign push = valid_i & ready_o;
	assign pop = valid_o & ready_i;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (push)
			mem[wr_ptr] <= data_i;
	end

endmodule

// ==== source/uart_rx.sv ====
`timescale 1ns/10ps

module uart_rx (
	input logic clock,
	input logic reset,
	input logic rxd_i,
	output bt_link_pkg::byte_t data_o,
	output logic valid_o
);
	import uart_pkg::*;

	typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_t;

	rx_state_t state;
	logic rxd_meta;
	logic rxd_sync;
	logic bit_end;
	logic half_end;
	logic [CYCLE_W-1:0] cycle_cnt;
	logic [BIT_W-1:0] bit_cnt;

	assign bit_end = (cycle_cnt == CYCLE_W'(CLOCKS_PER_BIT - 1));
	assign half_end = (cycle_cnt == CYCLE_W'(HALF_BIT - 1));

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
		end
		else
		begin
			rxd_meta <= rxd_i;
			rxd_sync <= rxd_meta;
		end
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= rx_idle;
			cycle_cnt <= '0;
			bit_cnt <= '0;
			valid_o <= 1'b0;
		end
		else
		begin
			valid_o <= 1'b0;
			cycle_cnt <= cycle_cnt + 1'b1;
			case (state)
				rx_idle:
				begin
					cycle_cnt <= '0;
					if (!rxd_sync)
						state <= rx_start;
				end
				rx_start:
				begin
					if (half_end)
					begin
						cycle_cnt <= '0;
						bit_cnt <= '0;
						state <= rxd_sync ? rx_idle : rx_data; // A glitch is not a start bit
					end
				end
				rx_data:
				begin
					if (bit_end)
					begin
						cycle_cnt <= '0;
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == BIT_W'(DATA_BITS - 1))
							state <= rx_stop;
					end
				end
				rx_stop:
				begin
					if (bit_end)
					begin
						state <= rx_idle;
						valid_o <= rxd_sync; // Framing error drops the byte
					end
				end
				default: state <= rx_idle;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (state == rx_data && bit_end)
			data_o <= {rxd_sync, data_o[DATA_BITS-1:1]};
	end

endmodule

// ==== source/uart_tx.sv ====
`timescale 1ns/10ps

module uart_tx (
	input logic clock,
	input logic reset,
	input bt_link_pkg::byte_t data_i,
	input logic valid_i,
	output logic ready_o,
	output logic txd_o
);
	import uart_pkg::*;

	logic busy;
	logic accept;
	logic bit_end;
	logic [CYCLE_W-1:0] cycle_cnt;
	logic [BIT_W-1:0] bit_cnt;
	logic [DATA_BITS:0] shift_q; // Data bits with the stop bit above them

	assign ready_o = ~busy;
	assign accept = valid_i & ~busy;
	assign bit_end = (cycle_cnt == CYCLE_W'(CLOCKS_PER_BIT - 1));

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			cycle_cnt <= '0;
			bit_cnt <= '0;
			txd_o <= 1'b1;
		end
		else if (accept)
		begin
			busy <= 1'b1;
			cycle_cnt <= '0;
			bit_cnt <= '0;
			txd_o <= 1'b0; // Start bit begins on the next cycle
		end
		else if (busy)
		begin
			if (bit_end)
			begin
				cycle_cnt <= '0;
				if (bit_cnt == BIT_W'(FRAME_BITS - 1))
					busy <= 1'b0; // Stop bit finished and the line stays high
				else
				begin
					bit_cnt <= bit_cnt + 1'b1;
					txd_o <= shift_q[0];
				end
			end
			else
				cycle_cnt <= cycle_cnt + 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (accept)
			shift_q <= {1'b1, data_i};
		else if (busy && bit_end)
			shift_q <= {1'b1, shift_q[DATA_BITS:1]}; // LSB first
	end

endmodule

// ==== source/bt_link_pkg.sv ====
package bt_link_pkg;

	// ----------------------------------------------------------
	// Payload types
	// ----------------------------------------------------------
	typedef logic [15:0] word_t;
	typedef logic [7:0] byte_t;

	typedef struct packed {
		logic start;           // Held high for the whole exchange
		logic expect_response; // Receive a CR LF terminated reply after sending
	} link_cmd_t;

	// ----------------------------------------------------------
	// Controller states
	// ----------------------------------------------------------
	typedef enum logic [2:0] {
		idle,
		wait_connect,
		load_byte,
		send_byte,
		receive,
		done
	} link_state_t;

	// FIFO depths must be powers of two
	localparam int TX_DEPTH = 16;
	localparam int RX_DEPTH = 32;

	localparam byte_t CHAR_CR = 8'h0D;
	localparam byte_t CHAR_LF = 8'h0A;

endpackage

// ==== source/uart_pkg.sv ====
package uart_pkg;

	// ----------------------------------------------------------
	// Bit timing
	// ----------------------------------------------------------
	localparam int CLOCKS_PER_BIT = 8; // Short bit time keeps simulation fast
	localparam int HALF_BIT = CLOCKS_PER_BIT / 2;
	localparam int CYCLE_W = $clog2(CLOCKS_PER_BIT);

	// ----------------------------------------------------------
	// 8N1 framing
	// ----------------------------------------------------------
	localparam int DATA_BITS = 8;
	localparam int FRAME_BITS = DATA_BITS + 2; // Start bit, data bits and stop bit
	localparam int BIT_W = $clog2(FRAME_BITS);

endpackage
